// File: list.f
+incdir+src
src/rsp_order_pkg.sv
src/tag_heap.sv
src/read_reorder.sv
src/write_mdata_restore.sv
src/rsp_order_shim.sv
tb/rsp_order_asserts.sv
tb/rsp_order_tb.sv

// File: tb/rsp_order_tb.sv
`timescale 1ns/1ps

`include "rsp_order_macros.svh"

module rsp_order_tb
    import rsp_order_pkg::*;
();

    localparam logic [63:0] RD_XOR = 64'h5a5a_0000_0000_0000;
    localparam int SLACK = `RO_ALM_FULL_SLACK;
    localparam int N_ROWS = 6;
    localparam int ROW_TIMEOUT = 600;
    localparam int DRAIN_TIMEOUT = 600;

    // One stimulus row is a burst of reads or writes with a fabric stall at its start
    typedef struct packed {
        logic       is_wr;
        logic [7:0] count;
        t_addr      base_addr;
        t_mdata     base_mdata;
        logic [7:0] hold;
    } t_stim_row;

    logic    clk = 1'b0;
    logic    rst_n;
    t_rd_req afu_rd_req;
    t_wr_req afu_wr_req;
    t_rd_rsp afu_rd_rsp;
    t_wr_rsp afu_wr_rsp;
    logic    afu_rd_alm_full;
    logic    afu_wr_alm_full;
    t_rd_req fiu_rd_req;
    t_wr_req fiu_wr_req;
    t_rd_rsp fiu_rd_rsp;
    t_wr_rsp fiu_wr_rsp;
    logic    fiu_rd_alm_full;
    logic    fiu_wr_alm_full;

    t_stim_row stim_table [N_ROWS];

    // Tags in flight at the fabric model, which answers them in shuffled order
    t_tag   rd_out_tag [$];
    t_addr  rd_out_addr [$];
    t_tag   wr_out_tag [$];
    t_mdata wr_tag_mdata [`RO_N_ENTRIES];

    // Reads expected back from the shim in issue order
    t_mdata exp_rd_mdata [$];
    t_addr  exp_rd_addr [$];

    // Write answered last cycle and due on the AFU side now
    logic   pend_wr_valid;
    t_mdata pend_wr_mdata;

    logic [31:0] rng;
    int hold_cnt;
    int rd_slack_left;
    int wr_slack_left;
    int rd_issued;
    int rd_done;
    int wr_issued;
    int wr_done;
    logic saw_rd_af;
    logic saw_wr_af;

    rsp_order_shim #(
        .SYNC_REQ_CHANNELS (1)
    ) i_rsp_order_shim (
        .clk             (clk),
        .rst_n           (rst_n),
        .afu_rd_req      (afu_rd_req),
        .afu_wr_req      (afu_wr_req),
        .afu_rd_rsp      (afu_rd_rsp),
        .afu_wr_rsp      (afu_wr_rsp),
        .afu_rd_alm_full (afu_rd_alm_full),
        .afu_wr_alm_full (afu_wr_alm_full),
        .fiu_rd_req      (fiu_rd_req),
        .fiu_wr_req      (fiu_wr_req),
        .fiu_rd_rsp      (fiu_rd_rsp),
        .fiu_wr_rsp      (fiu_wr_rsp),
        .fiu_rd_alm_full (fiu_rd_alm_full),
        .fiu_wr_alm_full (fiu_wr_alm_full)
    );

    always #20 clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act)
        begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_reset_state(input string when);
        check_value({when, " afu_rd_rsp valid"}, 0, afu_rd_rsp.valid);
        check_value({when, " afu_wr_rsp valid"}, 0, afu_wr_rsp.valid);
        check_value({when, " fiu_rd_req valid"}, 0, fiu_rd_req.valid);
        check_value({when, " fiu_wr_req valid"}, 0, fiu_wr_req.valid);
        check_value({when, " afu_rd_alm_full"}, 0, afu_rd_alm_full);
        check_value({when, " afu_wr_alm_full"}, 0, afu_wr_alm_full);
    endtask

    // Compares the registered AFU outputs with the expected queues each cycle
    task automatic check_outputs();
        // The bound checker fails at a rising edge, so stop at the next falling one
        if (i_rsp_order_shim.i_rsp_order_asserts.assert_fail_cnt != 0)
        begin
            fail_run("A concurrent assertion on the shim failed");
        end
        saw_rd_af = saw_rd_af | afu_rd_alm_full;
        saw_wr_af = saw_wr_af | afu_wr_alm_full;
        // A low flag hands the AFU its full slack again
        if (!afu_rd_alm_full)
        begin
            rd_slack_left = SLACK;
        end
        if (!afu_wr_alm_full)
        begin
            wr_slack_left = SLACK;
        end
        if (afu_rd_rsp.valid)
        begin
            if (exp_rd_mdata.size() == 0)
            begin
                fail_run("Read response arrived with no read outstanding");
            end
            else
            begin
                check_value("read order mdata", exp_rd_mdata[0], afu_rd_rsp.mdata);
                check_value("read data", t_data'(exp_rd_addr[0]) ^ RD_XOR, afu_rd_rsp.data);
                void'(exp_rd_mdata.pop_front());
                void'(exp_rd_addr.pop_front());
                rd_done++;
            end
        end
        check_value("write response valid", pend_wr_valid, afu_wr_rsp.valid);
        if (pend_wr_valid)
        begin
            check_value("write restored mdata", pend_wr_mdata, afu_wr_rsp.mdata);
            wr_done++;
        end
    endtask

    // Fabric model answers at most one read and one write per cycle
    task automatic answer_fabric();
        int idx;
        fiu_rd_rsp = '0;
        fiu_wr_rsp = '0;
        pend_wr_valid = 1'b0;
        if (hold_cnt > 0)
        begin
            hold_cnt--;
        end
        else
        begin
            rng = xorshift32(rng);
            if (rng[1:0] != 2'b00 && rd_out_tag.size() > 0)
            begin
                idx = int'(rng[23:8]) % rd_out_tag.size();
                fiu_rd_rsp.valid = 1'b1;
                fiu_rd_rsp.mdata = t_mdata'(rd_out_tag[idx]);
                fiu_rd_rsp.data = t_data'(rd_out_addr[idx]) ^ RD_XOR;
                rd_out_tag.delete(idx);
                rd_out_addr.delete(idx);
            end
            rng = xorshift32(rng);
            if (rng[1:0] != 2'b00 && wr_out_tag.size() > 0)
            begin
                idx = int'(rng[23:8]) % wr_out_tag.size();
                fiu_wr_rsp.valid = 1'b1;
                fiu_wr_rsp.mdata = t_mdata'(wr_out_tag[idx]);
                pend_wr_valid = 1'b1;
                pend_wr_mdata = wr_tag_mdata[wr_out_tag[idx]];
                wr_out_tag.delete(idx);
            end
        end
    endtask

    // Drives one AFU request and checks the tagged copy on the FIU side
    task automatic drive_request(input logic go, input logic is_wr, input t_addr addr,
                                 input t_mdata mdata);
        logic found;
        t_tag tag;
        afu_rd_req = '0;
        afu_wr_req = '0;
        if (go && !is_wr)
        begin
            afu_rd_req.valid = 1'b1;
            afu_rd_req.addr = addr;
            afu_rd_req.mdata = mdata;
        end
        if (go && is_wr)
        begin
            afu_wr_req.valid = 1'b1;
            afu_wr_req.addr = addr;
            afu_wr_req.data = {~addr, addr};
            afu_wr_req.mdata = mdata;
        end
        #1;
        check_value("fiu_rd_req valid", go && !is_wr, fiu_rd_req.valid);
        check_value("fiu_wr_req valid", go && is_wr, fiu_wr_req.valid);
        found = 1'b0;
        if (go && !is_wr)
        begin
            tag = t_tag'(fiu_rd_req.mdata);
            foreach (rd_out_tag[i])
            begin
                found = found | (rd_out_tag[i] == tag);
            end
            check_value("fiu read addr", addr, fiu_rd_req.addr);
            check_value("fiu read tag upper bits", 0, fiu_rd_req.mdata >> `RO_TAG_BITS);
            check_value("fiu read tag already outstanding", 0, found);
            rd_out_tag.push_back(tag);
            rd_out_addr.push_back(addr);
            exp_rd_mdata.push_back(mdata);
            exp_rd_addr.push_back(addr);
            rd_issued++;
        end
        if (go && is_wr)
        begin
            tag = t_tag'(fiu_wr_req.mdata);
            foreach (wr_out_tag[i])
            begin
                found = found | (wr_out_tag[i] == tag);
            end
            check_value("fiu write addr", addr, fiu_wr_req.addr);
            check_value("fiu write data", {~addr, addr}, fiu_wr_req.data);
            check_value("fiu write tag upper bits", 0, fiu_wr_req.mdata >> `RO_TAG_BITS);
            check_value("fiu write tag already outstanding", 0, found);
            wr_out_tag.push_back(tag);
            wr_tag_mdata[tag] = mdata;
            wr_issued++;
        end
    endtask

    // ============================================================
    // Row issue and drain
    // ============================================================

    task automatic issue_row(input t_stim_row row);
        int issued;
        int guard;
        logic flag;
        logic go;
        issued = 0;
        guard = 0;
        hold_cnt = row.hold;
        saw_rd_af = 1'b0;
        saw_wr_af = 1'b0;
        while (issued < int'(row.count))
        begin
            @(negedge clk);
            check_outputs();
            answer_fabric();
            flag = row.is_wr ? afu_wr_alm_full : afu_rd_alm_full;
            // Past the flag the AFU may still spend its slack
            go = !flag || (row.is_wr ? wr_slack_left > 0 : rd_slack_left > 0);
            if (flag && go && row.is_wr)
            begin
                wr_slack_left--;
            end
            if (flag && go && !row.is_wr)
            begin
                rd_slack_left--;
            end
            drive_request(go, row.is_wr, t_addr'(row.base_addr + issued),
                          t_mdata'(row.base_mdata + issued));
            if (go)
            begin
                issued++;
            end
            guard++;
            if (guard > ROW_TIMEOUT)
            begin
                fail_run("Stimulus row did not finish issuing before the timeout");
            end
        end
        // A stalled fabric must push both synchronized flags up
        if (row.hold > 0)
        begin
            check_value("back-pressure afu_rd_alm_full", 1, saw_rd_af);
            check_value("back-pressure afu_wr_alm_full", 1, saw_wr_af);
        end
    endtask

    task automatic drain_all();
        int guard;
        guard = 0;
        while (exp_rd_mdata.size() > 0 || rd_out_tag.size() > 0 ||
               wr_out_tag.size() > 0 || pend_wr_valid)
        begin
            @(negedge clk);
            check_outputs();
            answer_fabric();
            drive_request(1'b0, 1'b0, '0, '0);
            guard++;
            if (guard > DRAIN_TIMEOUT)
            begin
                fail_run("Outstanding responses did not drain before the timeout");
            end
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        rst_n = 1'b0;
        afu_rd_req = '0;
        afu_wr_req = '0;
        fiu_rd_rsp = '0;
        fiu_wr_rsp = '0;
        fiu_rd_alm_full = 1'b0;
        fiu_wr_alm_full = 1'b0;
        rng = 32'h4e69;
        hold_cnt = 0;
        rd_slack_left = SLACK;
        wr_slack_left = SLACK;
        rd_issued = 0;
        rd_done = 0;
        wr_issued = 0;
        wr_done = 0;
        pend_wr_valid = 1'b0;
        pend_wr_mdata = '0;
        saw_rd_af = 1'b0;
        saw_wr_af = 1'b0;

        // Rows with a hold fill the shim before the fabric answers again
        stim_table[0] = '{1'b0, 8'd8, 32'h0000_1000, 16'h0100, 8'd0};
        stim_table[1] = '{1'b1, 8'd8, 32'h0000_2000, 16'h0200, 8'd0};
        stim_table[2] = '{1'b0, 8'd24, 32'h0000_3000, 16'h0300, 8'd40};
        stim_table[3] = '{1'b1, 8'd24, 32'h0000_4000, 16'h0400, 8'd40};
        stim_table[4] = '{1'b0, 8'd12, 32'h0000_5000, 16'h0500, 8'd0};
        stim_table[5] = '{1'b1, 8'd12, 32'h0000_6000, 16'h0600, 8'd0};

        repeat (3)
        begin
            @(negedge clk);
            check_reset_state("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state("after reset");

        for (int r = 0; r < N_ROWS; r++)
        begin
            issue_row(stim_table[r]);
        end
        drain_all();
        check_value("read response count", rd_issued, rd_done);
        check_value("write response count", wr_issued, wr_done);

        // Fabric write flag alone must stall both AFU channels
        @(negedge clk);
        fiu_wr_alm_full = 1'b1;
        #1;
        check_value("fiu_wr_alm_full to afu_rd_alm_full", 1, afu_rd_alm_full);
        check_value("fiu_wr_alm_full to afu_wr_alm_full", 1, afu_wr_alm_full);
        @(negedge clk);
        fiu_wr_alm_full = 1'b0;
        #1;
        check_value("released afu_rd_alm_full", 0, afu_rd_alm_full);
        check_value("released afu_wr_alm_full", 0, afu_wr_alm_full);

        @(negedge clk);
        if (i_rsp_order_shim.i_rsp_order_asserts.assert_fail_cnt != 0)
        begin
            $display("Concurrent assertions failed %0d times",
                     i_rsp_order_shim.i_rsp_order_asserts.assert_fail_cnt);
            $display("TEST FAIL");
            $fatal(1, "assertion failures");
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: tb/rsp_order_asserts.sv
`timescale 1ns/1ps

`include "rsp_order_macros.svh"

module rsp_order_asserts
    import rsp_order_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input t_rd_req fiu_rd_req,
    input t_rd_rsp fiu_rd_rsp,
    input t_rd_rsp afu_rd_rsp,
    input t_wr_rsp fiu_wr_rsp,
    input t_wr_rsp afu_wr_rsp
);

    localparam int N_ENTRIES = `RO_N_ENTRIES;

    // Read tags sent to the fabric and not yet answered
    logic [N_ENTRIES-1:0] rd_pending;

    // Slots held from the FIU request until the ordered AFU response
    int rd_used;

    // Number of failed assertions so far
    int assert_fail_cnt = 0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_pending <= '0;
            rd_used <= 0;
        end
        else
        begin
            if (fiu_rd_req.valid)
            begin
                rd_pending[t_tag'(fiu_rd_req.mdata)] <= 1'b1;
            end
            if (fiu_rd_rsp.valid)
            begin
                rd_pending[t_tag'(fiu_rd_rsp.mdata)] <= 1'b0;
            end
            rd_used <= rd_used + int'(fiu_rd_req.valid) - int'(afu_rd_rsp.valid);
        end
    end

    // ============================================================
    // Tag and ordering rules
    // ============================================================

    // The fabric may only answer a tag that is in flight
    a_rd_tag_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_rd_rsp.valid |-> rd_pending[t_tag'(fiu_rd_rsp.mdata)])
    else
    begin
        $error("read response carries a tag that is not outstanding");
        assert_fail_cnt++;
    end

    // All slots taken means no further read may be forwarded
    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_rd_req.valid |-> (rd_used < N_ENTRIES))
    else
    begin
        $error("read slot allocated while the reorder buffer is full");
        assert_fail_cnt++;
    end

    // Heap lookup is registered, so the restored response trails by one edge
    a_wr_rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
        fiu_wr_rsp.valid |=> afu_wr_rsp.valid)
    else
    begin
        $error("write response not delivered one cycle after the fabric response");
        assert_fail_cnt++;
    end

    a_wr_rsp_caused: assert property (@(posedge clk) disable iff (!rst_n)
        afu_wr_rsp.valid |-> $past(fiu_wr_rsp.valid))
    else
    begin
        $error("write response without a fabric response one cycle earlier");
        assert_fail_cnt++;
    end

endmodule

bind rsp_order_shim rsp_order_asserts i_rsp_order_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .fiu_rd_req (fiu_rd_req),
    .fiu_rd_rsp (fiu_rd_rsp),
    .afu_rd_rsp (afu_rd_rsp),
    .fiu_wr_rsp (fiu_wr_rsp),
    .afu_wr_rsp (afu_wr_rsp)
);

// File: src/rsp_order_shim.sv
`timescale 1ns/1ps

module rsp_order_shim
    import rsp_order_pkg::*;
#(
    parameter int SYNC_REQ_CHANNELS = 1
)
(
    input  logic    clk,
    input  logic    rst_n,

    // AFU side
    input  t_rd_req afu_rd_req,
    input  t_wr_req afu_wr_req,
    output t_rd_rsp afu_rd_rsp,
    output t_wr_rsp afu_wr_rsp,
    output logic    afu_rd_alm_full,
    output logic    afu_wr_alm_full,

    // FIU side
    output t_rd_req fiu_rd_req,
    output t_wr_req fiu_wr_req,
    input  t_rd_rsp fiu_rd_rsp,
    input  t_wr_rsp fiu_wr_rsp,
    input  logic    fiu_rd_alm_full,
    input  logic    fiu_wr_alm_full
);

    // Local full flags, each already registered inside its block
    logic rd_full;
    logic wr_full;

    logic rd_alm_full;
    logic wr_alm_full;

    // ============================================================
    // Read channel, sorted through the reorder buffer
    // ============================================================

    read_reorder i_read_reorder (
        .clk     (clk),
        .rst_n   (rst_n),
        .afu_req (afu_rd_req),
        .fiu_req (fiu_rd_req),
        .fiu_rsp (fiu_rd_rsp),
        .afu_rsp (afu_rd_rsp),
        .full    (rd_full)
    );

    // ============================================================
    // Write channel, mdata saved and restored
    // ============================================================

    write_mdata_restore i_write_mdata_restore (
        .clk     (clk),
        .rst_n   (rst_n),
        .afu_req (afu_wr_req),
        .fiu_req (fiu_wr_req),
        .fiu_rsp (fiu_wr_rsp),
        .afu_rsp (afu_wr_rsp),
        .full    (wr_full)
    );

    // ============================================================
    // Almost-full merge
    // ============================================================

    // A channel stalls on its own fabric flag or on its local block filling
    assign rd_alm_full = fiu_rd_alm_full || rd_full;
    assign wr_alm_full = fiu_wr_alm_full || wr_full;

    // Tying the channels together keeps loads and stores in issue order
    generate
        if (SYNC_REQ_CHANNELS != 0)
        begin : g_sync
            assign afu_rd_alm_full = rd_alm_full || wr_alm_full;
            assign afu_wr_alm_full = rd_alm_full || wr_alm_full;
        end
        else
        begin : g_split
            assign afu_rd_alm_full = rd_alm_full;
            assign afu_wr_alm_full = wr_alm_full;
        end
    endgenerate

endmodule

// File: src/write_mdata_restore.sv
`timescale 1ns/1ps

`include "rsp_order_macros.svh"

module write_mdata_restore
    import rsp_order_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  t_wr_req afu_req,
    output t_wr_req fiu_req,
    input  t_wr_rsp fiu_rsp,
    output t_wr_rsp afu_rsp,
    output logic    full
);

    t_tag   alloc_idx;
    t_tag   rsp_idx;
    t_mdata saved_mdata;
    logic   not_full;

    // Response valid is delayed to line up with the registered heap read
    logic   rsp_valid;

    // The fabric hands back the heap index in the low mdata bits
    assign rsp_idx = t_tag'(fiu_rsp.mdata);

    // ============================================================
    // Mdata heap
    // ============================================================

    // Every valid write takes an index and is released by its response
    tag_heap #(
        .T_PAYLOAD (t_mdata),
        .N_ENTRIES (`RO_N_ENTRIES)
    ) i_tag_heap (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq       (afu_req.valid),
        .enq_data  (afu_req.mdata),
        .alloc_idx (alloc_idx),
        .not_full  (not_full),
        .rd_idx    (rsp_idx),
        .rd_data   (saved_mdata),
        .free      (fiu_rsp.valid),
        .free_idx  (rsp_idx)
    );

    assign full = !not_full;

    // ============================================================
    // Request and response paths
    // ============================================================

    // Address and data pass untouched, only mdata is swapped for the index
    always_comb
    begin
        fiu_req = afu_req;
        fiu_req.mdata = t_mdata'(alloc_idx);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= fiu_rsp.valid;
        end
    end

    // Write responses keep fabric order, one cycle behind the FIU
    always_comb
    begin
        afu_rsp.valid = rsp_valid;
        afu_rsp.mdata = saved_mdata;
    end

endmodule

// File: src/read_reorder.sv
`timescale 1ns/1ps

`include "rsp_order_macros.svh"

module read_reorder
    import rsp_order_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  t_rd_req afu_req,
    output t_rd_req fiu_req,
    input  t_rd_rsp fiu_rsp,
    output t_rd_rsp afu_rsp,
    output logic    full
);

    localparam int N_ENTRIES = `RO_N_ENTRIES;
    localparam int RESERVE = `RO_ALM_FULL_SLACK + 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // Slots are allocated at the tail and retired at the head, both wrap
    t_tag head;
    t_tag tail;
    logic [CNT_BITS-1:0] cnt;

    // Set when the fabric has answered the slot and cleared when it retires
    logic [N_ENTRIES-1:0] filled;

    t_mdata mdata_mem [N_ENTRIES];
    t_data  data_mem [N_ENTRIES];

    // Slot named by the returning response
    t_tag rsp_idx;
    logic head_ready;

    logic   out_valid;
    t_mdata out_mdata;
    t_data  out_data;

    assign rsp_idx = t_tag'(fiu_rsp.mdata);
    assign head_ready = filled[head];

    // ============================================================
    // Request path
    // ============================================================

    // The request goes out in the same cycle with the tail slot as its tag
    always_comb
    begin
        fiu_req = afu_req;
        fiu_req.mdata = t_mdata'(tail);
    end

    // ============================================================
    // Slot control
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            head <= '0;
            tail <= '0;
            cnt <= '0;
            filled <= '0;
            out_valid <= 1'b0;
            full <= 1'b0;
        end
        else
        begin
            if (afu_req.valid)
            begin
                tail <= tail + 1'b1;
            end

            // The head retires at most one slot per cycle
            if (head_ready)
            begin
                filled[head] <= 1'b0;
                head <= head + 1'b1;
            end

            // An answered slot is never the filled head, so no conflict here
            if (fiu_rsp.valid)
            begin
                filled[rsp_idx] <= 1'b1;
            end

            out_valid <= head_ready;

            case ({afu_req.valid, head_ready})
                2'b10: cnt <= cnt + 1'b1;
                2'b01: cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase

            // full once only the reserve is left, seen one cycle later
            full <= (cnt >= CNT_BITS'(N_ENTRIES - RESERVE));
        end
    end

    // Original mdata waits in its slot, data lands when the fabric answers
    always_ff @(posedge clk)
    begin
        if (afu_req.valid)
        begin
            mdata_mem[tail] <= afu_req.mdata;
        end
        if (fiu_rsp.valid)
        begin
            data_mem[rsp_idx] <= fiu_rsp.data;
        end
        if (head_ready)
        begin
            out_mdata <= mdata_mem[head];
            out_data <= data_mem[head];
        end
    end

    // Responses leave in request order with the AFU's own mdata
    always_comb
    begin
        afu_rsp.valid = out_valid;
        afu_rsp.mdata = out_mdata;
        afu_rsp.data = out_data;
    end

endmodule

// File: src/tag_heap.sv
`timescale 1ns/1ps

`include "rsp_order_macros.svh"

module tag_heap
    import rsp_order_pkg::*;
#(
    parameter type T_PAYLOAD = logic,
    parameter int N_ENTRIES = `RO_N_ENTRIES
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enq,
    input  T_PAYLOAD enq_data,
    output t_tag     alloc_idx,
    output logic     not_full,
    input  t_tag     rd_idx,
    output T_PAYLOAD rd_data,
    input  logic     free,
    input  t_tag     free_idx
);

    // Entries held back so that requests in flight after not_full drops still fit
    localparam int RESERVE = `RO_ALM_FULL_SLACK + 1;
    localparam int CNT_BITS = $clog2(N_ENTRIES + 1);

    // One bit per index, set while the index is handed out
    logic [N_ENTRIES-1:0] busy;
    logic [CNT_BITS-1:0] free_cnt;
    T_PAYLOAD mem [N_ENTRIES];

    // ============================================================
    // Allocation
    // ============================================================

    // Lowest free index wins; the loop walks down so the last hit is the lowest
    always_comb
    begin
        alloc_idx = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_idx = t_tag'(i);
            end
        end
    end

    // A freed index is never the one being allocated, since it is still busy
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= '0;
        end
        else
        begin
            if (free)
            begin
                busy[free_idx] <= 1'b0;
            end
            if (enq)
            begin
                busy[alloc_idx] <= 1'b1;
            end
        end
    end

    // Free count moves by at most one per cycle, so the reserve absorbs
    // the one-cycle lag of the registered flag plus the AFU slack
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            free_cnt <= CNT_BITS'(N_ENTRIES);
            not_full <= 1'b1;
        end
        else
        begin
            case ({enq, free})
                2'b10: free_cnt <= free_cnt - 1'b1;
                2'b01: free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
            not_full <= (free_cnt > CNT_BITS'(RESERVE));
        end
    end

    // ============================================================
    // Payload storage
    // ============================================================

    // Read is registered, so a lookup and free in the same cycle still
    // returns the old payload even if the index is reused at once
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[alloc_idx] <= enq_data;
        end
        rd_data <= mem[rd_idx];
    end

endmodule

// File: src/rsp_order_pkg.sv
`include "rsp_order_macros.svh"

package rsp_order_pkg;

    // ============================================================
    // Scalar field types
    // ============================================================

    // Reorder slot or write heap index
    typedef logic [`RO_TAG_BITS-1:0] t_tag;

    // Metadata as the AFU sees it; on the FIU side it holds a zero-extended t_tag
    typedef logic [`RO_MDATA_BITS-1:0] t_mdata;

    typedef logic [`RO_ADDR_BITS-1:0] t_addr;

    typedef logic [`RO_DATA_BITS-1:0] t_data;

    // ============================================================
    // Channel structs, shared by the AFU and FIU sides
    // ============================================================

    // Read request, throttled by the read almost-full flag
    typedef struct packed {
        logic   valid;
        t_addr  addr;
        t_mdata mdata;
    } t_rd_req;

    // Write request, throttled by the write almost-full flag
    typedef struct packed {
        logic   valid;
        t_addr  addr;
        t_data  data;
        t_mdata mdata;
    } t_wr_req;

    // Read response, valid-only and never refused
    typedef struct packed {
        logic   valid;
        t_mdata mdata;
        t_data  data;
    } t_rd_rsp;

    // Write response, also valid-only
    typedef struct packed {
        logic   valid;
        t_mdata mdata;
    } t_wr_rsp;

endpackage

// File: src/rsp_order_macros.svh
`ifndef RSP_ORDER_MACROS_SVH
`define RSP_ORDER_MACROS_SVH

// Outstanding reads, and separately outstanding writes, that the shim tracks
`define RO_N_ENTRIES 16

// Width of a reorder slot or heap index
`define RO_TAG_BITS 4

// AFU metadata width
`define RO_MDATA_BITS 16

// Request address width
`define RO_ADDR_BITS 32

// Cache-line payload, kept narrow for this build
`define RO_DATA_BITS 64

// Requests the AFU may still issue after it samples almost-full high
`define RO_ALM_FULL_SLACK 2

`endif
